// ==== Makefile ====
.PHONY: run clean

obj_dir/Vprocessor_tb: src.f $(wildcard hw/*.sv sim/*.sv)
	verilator --binary --timing -Wno-fatal -f src.f --top-module processor_tb \
		-Mdir obj_dir -o Vprocessor_tb

run: obj_dir/Vprocessor_tb
	./obj_dir/Vprocessor_tb | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hw/cpuIsaPkg.sv ====
package cpuIsaPkg;

    // machine word and register file geometry
    localparam int dataWidth    = 16;
    localparam int regAddrWidth = 3;
    localparam int numRegs      = 1 << regAddrWidth;

    // both memories are word addressed
    localparam int instrMemDepth  = 256;
    localparam int dataMemDepth   = 256;
    localparam int instrAddrWidth = $clog2(instrMemDepth);
    localparam int dataAddrWidth  = $clog2(dataMemDepth);

    // instruction field positions
    localparam int opMsb   = 15;
    localparam int opLsb   = 12;
    localparam int srcMsb  = 11;
    localparam int srcLsb  = 9;
    localparam int dstMsb  = 8;
    localparam int dstLsb  = 6;
    localparam int funcMsb = 3;
    localparam int funcLsb = 0;
    localparam int immMsb  = 5;
    localparam int immLsb  = 0;

    typedef logic [dataWidth-1:0]    word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;

    // zero opcode must stay NOP, flushed stages rely on it
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ALU  = 4'h1,
        OP_ADDI = 4'h2,
        OP_LDM  = 4'h3,
        OP_STD  = 4'h4,
        OP_IN   = 4'h5,
        OP_OUT  = 4'h6,
        OP_JMP  = 4'h7,
        OP_JZ   = 4'h8
    } opcode_e;

    // A is the src register, B the dst register (or immediate)
    typedef enum logic [3:0] {
        ADD = 4'h0,
        SUB = 4'h1,
        AND = 4'h2,
        OR  = 4'h3,
        NOT = 4'h4,
        SHL = 4'h5,
        SHR = 4'h6,
        MOV = 4'h7
    } aluFunc_e;

endpackage

// ==== hw/cpuPipePkg.sv ====
package cpuPipePkg;

    // decoded control, travels with the instruction down the pipe
    typedef struct packed {
        logic                regWrite;
        logic                memRead;
        logic                memWrite;
        logic                memToReg;
        logic                aluSrc;
        logic                isIn;
        logic                isOut;
        logic                jump;
        logic                jumpZero;
        cpuIsaPkg::aluFunc_e aluFunc;
    } ctrl_t;

    // fetch to decode
    typedef struct packed {
        cpuIsaPkg::word_t                           instruction;
        logic [cpuIsaPkg::instrAddrWidth-1:0] pc;
    } fdPayload_t;

    // decode to execute
    typedef struct packed {
        ctrl_t               ctrl;
        cpuIsaPkg::word_t    readData1;
        cpuIsaPkg::word_t    readData2;
        cpuIsaPkg::regAddr_t srcAddr;
        cpuIsaPkg::regAddr_t dstAddr;
        cpuIsaPkg::word_t    imm;
    } dePayload_t;

    // execute to memory
    typedef struct packed {
        ctrl_t               ctrl;
        cpuIsaPkg::word_t    aluResult;
        cpuIsaPkg::word_t    storeData;
        cpuIsaPkg::regAddr_t dstAddr;
    } emPayload_t;

    // memory to writeback, only what writeback and the output port need
    typedef struct packed {
        logic                regWrite;
        logic                isOut;
        cpuIsaPkg::word_t    writeData;
        cpuIsaPkg::regAddr_t dstAddr;
    } mwPayload_t;

    // operand source for execute
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_EM   = 2'd1,
        FWD_MW   = 2'd2
    } fwdSel_e;

endpackage

// ==== hw/decodeStage.sv ====
module decodeStage (
    input  logic                   clk1,
    input  cpuPipePkg::fdPayload_t fd,
    input  logic                   wbWrite,
    input  cpuIsaPkg::regAddr_t    wbAddr,
    input  cpuIsaPkg::word_t       wbData,
    input  cpuIsaPkg::word_t       inputPort,
    output cpuPipePkg::dePayload_t de
);
    import cpuIsaPkg::*;
    import cpuPipePkg::*;

    word_t    regFile [numRegs];
    opcode_e  opcode;
    regAddr_t srcAddr;
    regAddr_t dstAddr;
    ctrl_t    ctrl;

    // write-through so a same-cycle writeback is seen here
    function automatic word_t readReg(input regAddr_t addr);
        if (wbWrite && (wbAddr == addr)) begin
            return wbData;
        end
        return regFile[addr];
    endfunction

    always_ff @(posedge clk1) begin
        if (wbWrite) begin
            regFile[wbAddr] <= wbData;
        end
    end

    assign opcode  = opcode_e'(fd.instruction[opMsb:opLsb]);
    assign srcAddr = fd.instruction[srcMsb:srcLsb];
    assign dstAddr = fd.instruction[dstMsb:dstLsb];

    // NOP and unknown opcodes leave every bit at 0
    always_comb begin
        ctrl = '0;
        case (opcode)
            OP_ALU: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluFunc  = aluFunc_e'(fd.instruction[funcMsb:funcLsb]);
            end
            OP_ADDI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluFunc  = ADD;
            end
            // address is R[src], passed straight through the ALU
            OP_LDM: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluFunc  = MOV;
            end
            // mem[R[src]] = R[dst]
            OP_STD: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluFunc  = MOV;
            end
            OP_IN: begin
                ctrl.regWrite = 1'b1;
                ctrl.isIn     = 1'b1;
                ctrl.aluFunc  = MOV;
            end
            // outputs R[src]
            OP_OUT: begin
                ctrl.isOut   = 1'b1;
                ctrl.aluFunc = MOV;
            end
            OP_JMP:  ctrl.jump     = 1'b1;
            OP_JZ:   ctrl.jumpZero = 1'b1;
            default: ctrl = '0;
        endcase
    end

    always_comb begin
        de.ctrl      = ctrl;
        de.readData1 = readReg(srcAddr);
        // IN samples the port here, in decode
        de.readData2 = ctrl.isIn ? inputPort : readReg(dstAddr);
        de.srcAddr   = srcAddr;
        de.dstAddr   = dstAddr;
        // sign-extend the 6-bit immediate
        de.imm = {{(dataWidth - immMsb - 1){fd.instruction[immMsb]}},
                  fd.instruction[immMsb:immLsb]};
    end

endmodule

// ==== hw/executeStage.sv ====
module executeStage (
    input  logic                   clk1,
    input  logic                   rstN,
    input  cpuPipePkg::dePayload_t de,
    input  cpuPipePkg::fwdSel_e    fwdA,
    input  cpuPipePkg::fwdSel_e    fwdB,
    input  cpuIsaPkg::word_t       emFwd,
    input  cpuIsaPkg::word_t       mwFwd,
    output cpuPipePkg::emPayload_t em,
    output logic                   jumpTaken,
    output cpuIsaPkg::word_t       jumpTarget
);
    import cpuIsaPkg::*;
    import cpuPipePkg::*;

    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;
    } flags_t;

    flags_t               flags;
    word_t                opA;
    word_t                opB;
    word_t                aluB;
    logic [dataWidth:0]   aluWide;
    logic                 flagUpdate;

    // forwarding muxes
    always_comb begin
        case (fwdA)
            FWD_EM:  opA = emFwd;
            FWD_MW:  opA = mwFwd;
            default: opA = de.readData1;
        endcase
        case (fwdB)
            FWD_EM:  opB = emFwd;
            FWD_MW:  opB = mwFwd;
            default: opB = de.readData2;
        endcase
    end

    // immediate replaces B for add-immediate
    assign aluB = de.ctrl.aluSrc ? de.imm : opB;

    // top bit of aluWide is the carry out (borrow for SUB)
    always_comb begin
        case (de.ctrl.aluFunc)
            ADD:     aluWide = {1'b0, opA} + {1'b0, aluB};
            SUB:     aluWide = {1'b0, opA} - {1'b0, aluB};
            AND:     aluWide = {1'b0, opA & aluB};
            OR:      aluWide = {1'b0, opA | aluB};
            NOT:     aluWide = {1'b0, ~opA};
            SHL:     aluWide = {1'b0, opA} << aluB[3:0];
            SHR:     aluWide = {1'b0, opA >> aluB[3:0]};
            default: aluWide = {1'b0, opA};
        endcase
    end

    // ALU and add-immediate only, loads and IN leave flags alone
    assign flagUpdate = de.ctrl.regWrite && !de.ctrl.memRead && !de.ctrl.isIn;

    always_ff @(posedge clk1) begin
        if (!rstN) begin
            flags <= '0;
        end else if (flagUpdate) begin
            flags.zero     <= (aluWide[dataWidth-1:0] == '0);
            flags.negative <= aluWide[dataWidth-1];
            flags.carry    <= aluWide[dataWidth];
        end
    end

    // JZ reads the flags left by the last ALU op
    assign jumpTaken  = de.ctrl.jump || (de.ctrl.jumpZero && flags.zero);
    assign jumpTarget = opA;

    always_comb begin
        em.ctrl = de.ctrl;
        // IN carries the port value captured in decode, never forwarded
        em.aluResult = de.ctrl.isIn ? de.readData2 : aluWide[dataWidth-1:0];
        em.storeData = opB;
        em.dstAddr   = de.dstAddr;
    end

endmodule

// ==== hw/fetchStage.sv ====
module fetchStage (
    input  logic                                 clk1,
    input  logic                                 rstN,
    input  logic                                 stall,
    input  logic                                 jumpTaken,
    input  cpuIsaPkg::word_t                     jumpTarget,
    input  logic                                 progWrite,
    input  logic [cpuIsaPkg::instrAddrWidth-1:0] progAddr,
    input  cpuIsaPkg::word_t                     progData,
    output cpuPipePkg::fdPayload_t               fd
);
    import cpuIsaPkg::*;
    import cpuPipePkg::*;

    word_t                     instrMem [instrMemDepth];
    logic [instrAddrWidth-1:0] pc;

    // program load port, driven while the core sits in reset
    always_ff @(posedge clk1) begin
        if (progWrite) begin
            instrMem[progAddr] <= progData;
        end
    end

    // jump beats stall, the two never coincide anyway
    always_ff @(posedge clk1) begin
        if (!rstN) begin
            pc <= '0;
        end else if (jumpTaken) begin
            pc <= jumpTarget[instrAddrWidth-1:0];
        end else if (!stall) begin
            pc <= pc + 1'b1;
        end
    end

    // async read, word lands in the FD register on the edge
    always_comb begin
        fd.instruction = instrMem[pc];
        fd.pc          = pc;
    end

endmodule

// ==== hw/hazardUnit.sv ====
module hazardUnit (
    input  cpuIsaPkg::regAddr_t decSrc,
    input  cpuIsaPkg::regAddr_t decDst,
    input  logic                deMemRead,
    input  cpuIsaPkg::regAddr_t deDst,
    input  cpuIsaPkg::regAddr_t deSrc,
    input  cpuIsaPkg::regAddr_t exDst,
    input  logic                emRegWrite,
    input  cpuIsaPkg::regAddr_t emDst,
    input  logic                mwRegWrite,
    input  cpuIsaPkg::regAddr_t mwDst,
    input  logic                jumpTaken,
    output logic                stall,
    output logic                flushFd,
    output logic                flushDe,
    output cpuPipePkg::fwdSel_e fwdA,
    output cpuPipePkg::fwdSel_e fwdB
);
    import cpuPipePkg::*;

    // load in execute feeding the instruction in decode
    // both fields checked, a spare bubble is harmless
    assign stall = deMemRead && ((deDst == decSrc) || (deDst == decDst));

    // jump resolves in execute, kill the two younger stages
    assign flushFd = jumpTaken;
    assign flushDe = jumpTaken;

    // operand A follows the src field
    always_comb begin
        fwdA = FWD_NONE;
        if (emRegWrite && (emDst == deSrc)) begin
            fwdA = FWD_EM;
        end else if (mwRegWrite && (mwDst == deSrc)) begin
            fwdA = FWD_MW;
        end
    end

    // operand B follows the dst field
    // EM is the younger result so it wins
    always_comb begin
        fwdB = FWD_NONE;
        if (emRegWrite && (emDst == exDst)) begin
            fwdB = FWD_EM;
        end else if (mwRegWrite && (mwDst == exDst)) begin
            fwdB = FWD_MW;
        end
    end

endmodule

// ==== hw/memoryStage.sv ====
module memoryStage (
    input  logic                   clk1,
    input  cpuPipePkg::emPayload_t em,
    output cpuPipePkg::mwPayload_t mw
);
    import cpuIsaPkg::*;
    import cpuPipePkg::*;

    word_t                    dataMem [dataMemDepth];
    logic [dataAddrWidth-1:0] addr;
    word_t                    loadWord;

    // address comes from R[src] through the ALU
    assign addr = em.aluResult[dataAddrWidth-1:0];

    always_ff @(posedge clk1) begin
        if (em.ctrl.memWrite) begin
            dataMem[addr] <= em.storeData;
        end
    end

    // async read so the word is ready for the MW register
    assign loadWord = dataMem[addr];

    always_comb begin
        mw.regWrite = em.ctrl.regWrite;
        mw.isOut    = em.ctrl.isOut;
        mw.writeData = em.ctrl.memToReg ? loadWord : em.aluResult;
        mw.dstAddr  = em.dstAddr;
    end

endmodule

// ==== hw/pipeReg.sv ====
module pipeReg #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk1,
    input  logic     rstN,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // all-zero payload is a NOP in every stage
    always_ff @(posedge clk1) begin
        if (!rstN || flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
        // stalled, keep current payload
    end

endmodule

// ==== hw/processor.sv ====
module processor (
    input  logic                                 clk1,
    input  logic                                 rstN,
    input  cpuIsaPkg::word_t                     inputPort,
    input  logic                                 progWrite,
    input  logic [cpuIsaPkg::instrAddrWidth-1:0] progAddr,
    input  cpuIsaPkg::word_t                     progData,
    output cpuIsaPkg::word_t                     outputPort,
    output logic                                 outValid
);
    import cpuIsaPkg::*;
    import cpuPipePkg::*;

    fdPayload_t fdD, fdQ;
    dePayload_t deD, deQ;
    emPayload_t emD, emQ;
    mwPayload_t mwD, mwQ;
    logic       stall, flushFd, flushDe;
    logic       jumpTaken;
    word_t      jumpTarget;
    fwdSel_e    fwdA, fwdB;

    fetchStage fetchUnit (
        .clk1(clk1), .rstN(rstN), .stall(stall), .jumpTaken(jumpTaken),
        .jumpTarget(jumpTarget), .progWrite(progWrite), .progAddr(progAddr),
        .progData(progData), .fd(fdD)
    );
    pipeReg #(.payload_t(fdPayload_t)) fdReg (
        .clk1(clk1), .rstN(rstN), .stall(stall), .flush(flushFd), .d(fdD), .q(fdQ)
    );

    // writeback feeds the register file straight from MW
    decodeStage decodeUnit (
        .clk1(clk1), .fd(fdQ), .wbWrite(mwQ.regWrite), .wbAddr(mwQ.dstAddr),
        .wbData(mwQ.writeData), .inputPort(inputPort), .de(deD)
    );
    // a stall pushes a bubble into execute
    pipeReg #(.payload_t(dePayload_t)) deReg (
        .clk1(clk1), .rstN(rstN), .stall(1'b0), .flush(flushDe || stall),
        .d(deD), .q(deQ)
    );

    executeStage executeUnit (
        .clk1(clk1), .rstN(rstN), .de(deQ), .fwdA(fwdA), .fwdB(fwdB),
        .emFwd(emQ.aluResult), .mwFwd(mwQ.writeData), .em(emD),
        .jumpTaken(jumpTaken), .jumpTarget(jumpTarget)
    );
    pipeReg #(.payload_t(emPayload_t)) emReg (
        .clk1(clk1), .rstN(rstN), .stall(1'b0), .flush(1'b0), .d(emD), .q(emQ)
    );

    memoryStage memoryUnit (.clk1(clk1), .em(emQ), .mw(mwD));
    pipeReg #(.payload_t(mwPayload_t)) mwReg (
        .clk1(clk1), .rstN(rstN), .stall(1'b0), .flush(1'b0), .d(mwD), .q(mwQ)
    );

    hazardUnit hazard (
        .decSrc(fdQ.instruction[srcMsb:srcLsb]), .decDst(fdQ.instruction[dstMsb:dstLsb]),
        .deMemRead(deQ.ctrl.memRead), .deDst(deQ.dstAddr), .deSrc(deQ.srcAddr),
        .exDst(deQ.dstAddr), .emRegWrite(emQ.ctrl.regWrite), .emDst(emQ.dstAddr),
        .mwRegWrite(mwQ.regWrite), .mwDst(mwQ.dstAddr), .jumpTaken(jumpTaken),
        .stall(stall), .flushFd(flushFd), .flushDe(flushDe), .fwdA(fwdA), .fwdB(fwdB)
    );

    // output port, one cycle behind the OUT in MW
    always_ff @(posedge clk1) begin
        if (!rstN) begin
            outputPort <= '0;
            outValid   <= 1'b0;
        end else begin
            outValid <= mwQ.isOut;
            if (mwQ.isOut) begin
                outputPort <= mwQ.writeData;
            end
        end
    end

endmodule

// ==== sim/processorTb.sv ====
module processor_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import cpuIsaPkg::*;

    logic                      clk1;
    logic                      rstN;
    word_t                     inputPort;
    logic                      progWrite;
    logic [instrAddrWidth-1:0] progAddr;
    word_t                     progData;
    word_t                     outputPort;
    logic                      outValid;

    // test table with program words and outputs of all tests back to back
    string names[$];
    word_t portValues[$];
    int    wordCounts[$];
    word_t programWords[$];
    int    outCounts[$];
    word_t expectedOuts[$];
    // output port samples of the running test
    word_t received[$];
    int    valueErrors = 0;
    int    otherErrors = 0;
    int    watchCycles = 0;

    processor dut_i (
        .clk1(clk1), .rstN(rstN), .inputPort(inputPort), .progWrite(progWrite),
        .progAddr(progAddr), .progData(progData), .outputPort(outputPort),
        .outValid(outValid)
    );

    // 20 ns clock
    initial begin
        clk1 = 1'b0;
        forever #10 clk1 = ~clk1;
    end

    task automatic checkWord(input string testName, input string label,
                             input word_t expected, input word_t actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("** Error %s %s: expected %h, actual %h",
                     testName, label, expected, actual);
        end
    endtask

    task automatic checkCount(input string testName, input int expected, input int actual);
        if (actual != expected) begin
            valueErrors++;
            $display("** Error %s output count: expected %0d, actual %0d",
                     testName, expected, actual);
        end
    endtask

    task automatic readTests();
        int    fd;
        int    c;
        int    count;
        string tok;
        word_t value;
        fd = $fopen("sim/programInput.txt", "r");
        if (fd == 0) begin
            otherErrors++;
            $display("could not open sim/programInput.txt");
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.getc(0) == "#") begin
                // skip a comment to the end of its line
                c = $fgetc(fd);
                while (c != 10 && c != -1) begin
                    c = $fgetc(fd);
                end
            end else begin
                // name, port value, word count, words, output count, outputs
                names.push_back(tok);
                void'($fscanf(fd, "%h %d", value, count));
                portValues.push_back(value);
                wordCounts.push_back(count);
                for (int i = 0; i < count; i++) begin
                    void'($fscanf(fd, "%h", value));
                    programWords.push_back(value);
                end
                void'($fscanf(fd, "%d", count));
                outCounts.push_back(count);
                for (int i = 0; i < count; i++) begin
                    void'($fscanf(fd, "%h", value));
                    expectedOuts.push_back(value);
                end
            end
        end
        $fclose(fd);
        if (names.size() == 0) begin
            otherErrors++;
            $display("no tests found in sim/programInput.txt");
        end
    endtask

    // program is written while reset is held for at least 16 cycles
    task automatic loadProgram(input string testName, input int base, input int count);
        int cycles;
        cycles = (count > 16) ? count : 16;
        @(negedge clk1);
        rstN = 1'b0;
        for (int i = 0; i < cycles; i++) begin
            progWrite = (i < count);
            if (i < count) begin
                progAddr = instrAddrWidth'(i);
                progData = programWords[base + i];
            end
            @(negedge clk1);
            // port must read cleared once reset has seen an edge
            if (outValid !== 1'b0) begin
                otherErrors++;
                $display("%s: outValid went high while reset was held", testName);
            end
            checkWord(testName, "outputPort in reset", '0, outputPort);
        end
        progWrite = 1'b0;
        rstN      = 1'b1;
    endtask

    // samples at the falling edge until 12 quiet cycles pass the last expected output
    task automatic collectOutputs(input int expectedCount, input int budget);
        int waited;
        int quiet;
        waited = 0;
        quiet  = 0;
        received.delete();
        while (quiet < 12 && waited < budget) begin
            @(negedge clk1);
            waited++;
            if (outValid === 1'b1) begin
                received.push_back(outputPort);
            end
            if (received.size() >= expectedCount) begin
                quiet++;
            end
        end
    endtask

    task automatic runTest(input int t, input int wordBase, input int outBase);
        inputPort = portValues[t];
        loadProgram(names[t], wordBase, wordCounts[t]);
        collectOutputs(outCounts[t], 20 * wordCounts[t]);
        for (int i = 0; i < outCounts[t]; i++) begin
            if (i >= received.size()) begin
                otherErrors++;
                $display("%s: expected output %0d never appeared", names[t], i);
            end else begin
                checkWord(names[t], $sformatf("output %0d", i),
                          expectedOuts[outBase + i], received[i]);
            end
        end
        checkCount(names[t], outCounts[t], received.size());
    endtask

    initial begin
        int wordBase;
        int outBase;
        rstN      = 1'b0;
        inputPort = '0;
        progWrite = 1'b0;
        progAddr  = '0;
        progData  = '0;
        void'($urandom(39252));
        readTests();
        foreach (wordCounts[t]) begin
            watchCycles += 40 * wordCounts[t];
        end
        wordBase = 0;
        outBase  = 0;
        for (int t = 0; t < names.size(); t++) begin
            // idle gap while the previous program spins in its own loop
            repeat ($urandom_range(7, 0)) @(negedge clk1);
            runTest(t, wordBase, outBase);
            wordBase += wordCounts[t];
            outBase  += outCounts[t];
        end
        $display("value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog allows 40 cycles per program word
    initial begin
        wait (watchCycles > 0);
        repeat (watchCycles) @(posedge clk1);
        $display("timeout: tests did not finish within %0d cycles", watchCycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== sim/programInput.txt ====
# name  inputPort  wordCount, then program words, then outCount and expected outputs (hex)
# each program makes r0 zero with IN r0 and SUB r0, and ends in a jump to itself
aluChain 1234 13
  5000 1001 2045 2283 1280 6400 1281 6400 1245 12c4 6600 21cc 7e00
  3 000d fff8 ff5f
# store then load, loaded word used by the very next instruction
loadUse 0000 13
  5000 1001 2054 20bd 4280 32c0 6600 2109 3340 1b00 6800 21cc 7e00
  2 fffd 0006
inputEcho beef 8
  5000 1001 50c0 6600 2701 6800 21c7 7e00
  2 beef bef0
# taken JMP, JZ not taken, JZ taken, skipped OUTs stay silent
jumps 0055 17
  5000 1001 2186 7c00 6c00 6c00 2041 214e 8a00 6200 1241 8a00 6a00 6c00 6a00 21d0 7e00
  2 0001 000e
# short program over the longer one before it
restart 00a5 7
  5000 1001 209f 6400 6000 21c6 7e00
  2 001f 0000

// ==== src.f ====
hw/cpuIsaPkg.sv
hw/cpuPipePkg.sv
hw/pipeReg.sv
hw/hazardUnit.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/processor.sv
sim/processorTb.sv
